/* design/lane_stream_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface lane_stream_if import lane_test_pkg::*; ();

  lane_word_u word;   // aligned payload word
  logic       valid;  // word holds data
  logic       first;  // zero word of a payload
  logic       last;   // final count word

  // no back-pressure, the sink takes every valid word
  modport src (
    output word, valid, first, last
  );

  modport snk (
    input  word, valid, first, last
  );

endinterface

`default_nettype wire

/* design/lane_test_pkg.sv */
`default_nettype none

package lane_test_pkg;

  // K28.5 comma, sent on every byte lane during the comma phase
  localparam logic [7:0]  COMMA_BYTE = 8'hbc;
  localparam logic [31:0] COMMA_WORD = {4{COMMA_BYTE}};

  // frame layout: commas, one zero word, then the count payload
  localparam int COMMA_CYCLES  = 8;
  localparam int PAYLOAD_WORDS = 24;
  localparam int FRAME_LEN     = COMMA_CYCLES + 1 + PAYLOAD_WORDS;

  // wide enough for a position inside one frame
  localparam int POS_W = $clog2(FRAME_LEN);

  // one lane word
  // the aligner moves it around by byte lanes, the checker compares it
  // as a count value
  typedef union packed {
    logic [31:0]     cnt;    // whole word view
    logic [3:0][7:0] bytes;  // byte 0 is first on the lane
  } lane_word_u;

endpackage

`default_nettype wire

/* design/lane_test_top.sv */
`timescale 1ns/1ns
`default_nettype none

module lane_test_top (
  input  logic        txclk,
  input  logic        tx_rstn,
  output logic [31:0] o_txd,        // parallel word to the lane
  output logic [3:0]  o_txk,        // per byte K flags
  input  logic [31:0] i_rxd,        // parallel word from the lane
  input  logic [3:0]  i_rxk,
  output logic        o_aligned,
  output logic        o_locked,
  output logic        o_frame_ok,
  output logic [15:0] o_frame_cnt,
  output logic [15:0] o_err_cnt
);

  lane_stream_if i_lane_stream ();  // aligner to checker

  tx_pattern_gen i_tx_pattern_gen (
    .txclk       (txclk),
    .tx_rstn     (tx_rstn),
    .o_txd       (o_txd),
    .o_txk       (o_txk)
  );

  word_aligner i_word_aligner (
    .txclk       (txclk),
    .tx_rstn     (tx_rstn),
    .i_rxd       (i_rxd),
    .i_rxk       (i_rxk),
    .o_aligned   (o_aligned),
    .o_stream    (i_lane_stream.src)
  );

  pattern_checker i_pattern_checker (
    .txclk       (txclk),
    .tx_rstn     (tx_rstn),
    .i_stream    (i_lane_stream.snk),
    .o_locked    (o_locked),
    .o_frame_ok  (o_frame_ok),
    .o_frame_cnt (o_frame_cnt),
    .o_err_cnt   (o_err_cnt)
  );

endmodule

`default_nettype wire

/* design/pattern_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module pattern_checker import lane_test_pkg::*; (
  input  logic        txclk,
  input  logic        tx_rstn,
  lane_stream_if.snk  i_stream,
  output logic        o_locked,
  output logic        o_frame_ok,
  output logic [15:0] o_frame_cnt,
  output logic [15:0] o_err_cnt
);

  logic [31:0] exp_cnt;    // value expected for the next word
  logic [31:0] exp_word;
  logic        mism;
  logic        frame_bad;  // error seen earlier in this payload
  logic        bad_now;

  // the zero word restarts the sequence
  always_comb begin
    exp_word = i_stream.first ? 32'd0 : exp_cnt;
    mism     = i_stream.word.cnt != exp_word;
    bad_now  = mism || (frame_bad && !i_stream.first);
  end

  always_ff @(posedge txclk or negedge tx_rstn) begin
    if (!tx_rstn) begin
      exp_cnt     <= '0;
      frame_bad   <= 1'b0;
      o_locked    <= 1'b0;
      o_frame_ok  <= 1'b0;
      o_frame_cnt <= '0;
      o_err_cnt   <= '0;
    end else begin
      o_frame_ok <= 1'b0;
      if (i_stream.valid) begin
        exp_cnt   <= exp_word + 32'd1;   // one error per bad word
        frame_bad <= bad_now;
        if (mism) begin
          o_err_cnt <= o_err_cnt + 16'd1;
        end
        if (i_stream.last && !bad_now) begin
          o_frame_ok  <= 1'b1;
          o_frame_cnt <= o_frame_cnt + 16'd1;
          o_locked    <= 1'b1;           // held until reset
        end
      end
    end
  end

endmodule

`default_nettype wire

/* design/tx_pattern_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module tx_pattern_gen import lane_test_pkg::*; (
  input  logic       txclk,
  input  logic       tx_rstn,
  output lane_word_u o_txd,
  output logic [3:0] o_txk
);

  logic [POS_W-1:0] pos;       // frame position of the word on o_txd
  logic [POS_W-1:0] pos_nxt;
  logic             comma_ph;
  logic             zero_ph;

  assign pos_nxt  = (pos == POS_W'(FRAME_LEN - 1)) ? '0 : pos + 1'b1;

  // phase of the word that goes out on the next edge
  assign comma_ph = pos_nxt < POS_W'(COMMA_CYCLES);
  assign zero_ph  = pos_nxt == POS_W'(COMMA_CYCLES);

  always_ff @(posedge txclk or negedge tx_rstn) begin
    if (!tx_rstn) begin
      pos <= '0;
    end else begin
      pos <= pos_nxt;
    end
  end

  // word 0 of the frame is already on the lane while reset is held
  always_ff @(posedge txclk or negedge tx_rstn) begin
    if (!tx_rstn) begin
      o_txd.cnt <= COMMA_WORD;
      o_txk     <= 4'b1111;
    end else if (comma_ph) begin
      o_txd.cnt <= COMMA_WORD;
      o_txk     <= 4'b1111;
    end else if (zero_ph) begin
      o_txd.cnt <= '0;              // payload opener
      o_txk     <= 4'b0000;
    end else begin
      o_txd.cnt <= o_txd.cnt + 32'd1;
      o_txk     <= 4'b0000;
    end
  end

endmodule

`default_nettype wire

/* design/word_aligner.sv */
`timescale 1ns/1ns
`default_nettype none

module word_aligner import lane_test_pkg::*; (
  input  logic       txclk,
  input  logic       tx_rstn,
  input  lane_word_u i_rxd,
  input  logic [3:0] i_rxk,
  output logic       o_aligned,
  lane_stream_if.src o_stream
);

  lane_word_u       prev_d;        // last two received words
  lane_word_u       prev2_d;
  logic [3:0]       prev_k;
  logic [3:0]       prev2_k;
  logic [2:0]       rot_off;       // byte offset into {prev_d, prev2_d}
  logic [2:0]       off_nxt;
  logic             hit;
  logic [7:0][7:0]  cat_d;
  logic [7:0]       cat_k;
  lane_word_u       algn_d;
  logic [3:0]       algn_k;
  logic             algn_valid;
  logic             algn_first;
  logic             was_data;
  logic [POS_W-1:0] pay_cnt;       // number of the next payload word

  // A skew of s puts s comma bytes of the previous word into the low byte
  // lanes of the first data word, so its flags read 0001, 0011 or 0111.
  // With no skew the flags drop straight from all set to all clear.
  assign hit = (prev_k == 4'hf) && (i_rxk != 4'hf) && (prev_d.bytes[3] == COMMA_BYTE);

  always_comb begin
    case (i_rxk)
      4'b0001: off_nxt = 3'd1;
      4'b0011: off_nxt = 3'd2;
      4'b0111: off_nxt = 3'd3;
      default: off_nxt = 3'd4;     // boundary on a word edge
    endcase
  end

  always_ff @(posedge txclk or negedge tx_rstn) begin
    if (!tx_rstn) begin
      prev_k    <= 4'hf;
      prev2_k   <= 4'hf;
      rot_off   <= 3'd4;
      o_aligned <= 1'b0;
    end else begin
      prev_k  <= i_rxk;
      prev2_k <= prev_k;
      if (hit) begin
        rot_off   <= off_nxt;      // refreshed every frame
        o_aligned <= 1'b1;
      end
    end
  end

  always_ff @(posedge txclk) begin
    prev_d  <= i_rxd;
    prev2_d <= prev_d;
  end

  // the word that completed on the last cycle sits in the upper half
  assign cat_d = {prev_d.bytes, prev2_d.bytes};
  assign cat_k = {prev_k, prev2_k};

  always_comb begin
    for (int b = 0; b < 4; b++) begin
      algn_d.bytes[b] = cat_d[b + int'(rot_off)];
      algn_k[b]       = cat_k[b + int'(rot_off)];
    end
  end

  assign algn_valid = o_aligned && (algn_k == 4'b0000);
  assign algn_first = algn_valid && !was_data;

  always_ff @(posedge txclk or negedge tx_rstn) begin
    if (!tx_rstn) begin
      was_data       <= 1'b0;
      pay_cnt        <= '0;
      o_stream.valid <= 1'b0;
      o_stream.first <= 1'b0;
      o_stream.last  <= 1'b0;
    end else begin
      was_data       <= algn_valid;
      o_stream.valid <= algn_valid;
      o_stream.first <= algn_first;
      o_stream.last  <= algn_valid && !algn_first && (pay_cnt == POS_W'(PAYLOAD_WORDS));
      if (algn_first) begin
        pay_cnt <= POS_W'(1);      // zero word is number 0
      end else if (algn_valid) begin
        pay_cnt <= pay_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge txclk) begin
    o_stream.word <= algn_d;
  end

endmodule

`default_nettype wire

/* dv/lane_test_props.sv */
`timescale 1ns/1ns
`default_nettype none

module lane_test_props import lane_test_pkg::*; (
  input logic txclk,
  input logic tx_rstn,
  input logic i_aligned,
  input logic i_valid,
  input logic i_first,
  input logic i_last
);

  logic [7:0] gap;         // cycles since last
  logic       wait_first;

  always_ff @(posedge txclk or negedge tx_rstn) begin
    if (!tx_rstn) begin
      gap        <= '0;
      wait_first <= 1'b0;
    end else if (i_last) begin
      gap        <= '0;
      wait_first <= 1'b1;
    end else if (i_first) begin
      wait_first <= 1'b0;
    end else if (wait_first) begin
      gap <= gap + 8'd1;
    end
  end

  a_flags_need_valid: assert property (@(posedge txclk) disable iff (!tx_rstn)
    (i_first || i_last) |-> i_valid)
    else $error("first or last raised without valid");

  a_valid_after_align: assert property (@(posedge txclk) disable iff (!tx_rstn)
    i_valid |-> i_aligned)
    else $error("valid raised before the aligner latched a rotation");

  a_first_follows_last: assert property (@(posedge txclk) disable iff (!tx_rstn)
    wait_first |-> (gap < 8'(COMMA_CYCLES + 2)))
    else $error("no first word within the comma gap after last");

endmodule

`default_nettype wire

/* dv/lane_test_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module lane_test_tb import lane_test_pkg::*; ();

  localparam int MAX_TESTS   = 32;
  localparam int HOLD_CYCLES = 16;

  logic        txclk = 1'b0;
  logic        tx_rstn;
  logic [31:0] txd;
  logic [3:0]  txk;
  logic [31:0] rxd;
  logic [3:0]  rxk;
  logic        aligned;
  logic        locked;
  logic        frame_ok;
  logic [15:0] frame_cnt;
  logic [15:0] err_cnt;

  logic [15:0] test_mem [0:3*MAX_TESTS-1];  // skew, frames, error index
  logic [31:0] last_d;                       // previous lane word
  logic [3:0]  last_k;
  int          skew;
  int          frames;
  int          err_idx;
  int          cyc;                          // edges since reset release
  int          test_no;
  int          n_tests;
  int          n_checks;
  int          n_errors;
  int          run_cycles;
  int          cycle_limit;

  lane_test_top i_lane_test_top (
    .txclk       (txclk),
    .tx_rstn     (tx_rstn),
    .o_txd       (txd),
    .o_txk       (txk),
    .i_rxd       (rxd),
    .i_rxk       (rxk),
    .o_aligned   (aligned),
    .o_locked    (locked),
    .o_frame_ok  (frame_ok),
    .o_frame_cnt (frame_cnt),
    .o_err_cnt   (err_cnt)
  );

  bind word_aligner lane_test_props i_lane_test_props (
    .txclk     (txclk),
    .tx_rstn   (tx_rstn),
    .i_aligned (o_aligned),
    .i_valid   (o_stream.valid),
    .i_first   (o_stream.first),
    .i_last    (o_stream.last)
  );

  always #10 txclk = ~txclk;

  always @(posedge txclk) begin
    run_cycles = run_cycles + 1;
    if (cycle_limit > 0 && run_cycles >= cycle_limit) begin
      $display("Error: run reached its limit of %0d cycles without finishing", cycle_limit);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  // expected tx word at a frame position
  function automatic logic [31:0] exp_tx_word(int pos);
    if (pos < COMMA_CYCLES) return COMMA_WORD;
    if (pos == COMMA_CYCLES) return 32'd0;
    return 32'(pos - COMMA_CYCLES);
  endfunction

  function automatic logic [3:0] exp_tx_flags(int pos);
    return (pos < COMMA_CYCLES) ? 4'hf : 4'h0;
  endfunction

  // lane lags by sk bytes
  function automatic logic [31:0] skew_bytes(logic [31:0] cur, logic [31:0] prev, int sk);
    logic [63:0] cat;
    cat = {cur, prev};
    return cat[(4 - sk) * 8 +: 32];
  endfunction

  function automatic logic [3:0] skew_flags(logic [3:0] cur, logic [3:0] prev, int sk);
    logic [7:0] cat;
    cat = {cur, prev};
    return cat[(4 - sk) +: 4];
  endfunction

  task automatic compare_value(input string sig_name, input logic [31:0] got,
                               input logic [31:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("Mismatch %s: got 0x%h, expected 0x%h (test %0d, cycle %0d)",
               sig_name, got, exp, test_no, cyc);
    end
  endtask

  // drives the loopback word after each edge
  task automatic step_cycle();
    logic [31:0] tx_d;
    logic [3:0]  tx_k;
    @(posedge txclk);
    #2;
    if (tx_rstn) cyc++;
    tx_d = txd;
    tx_k = txk;
    if (tx_rstn && err_idx != 0 && cyc == COMMA_CYCLES + err_idx) tx_d[0] = ~tx_d[0];
    rxd    = skew_bytes(tx_d, last_d, skew);
    rxk    = skew_flags(tx_k, last_k, skew);
    last_d = tx_d;
    last_k = tx_k;
  endtask

  initial begin
    int idle;
    int run_len;
    int exp_frames;
    int exp_first;
    int pulses;
    int first_pulse;
    tx_rstn     = 1'b0;
    rxd         = '0;
    rxk         = '0;
    last_d      = COMMA_WORD;
    last_k      = 4'hf;
    skew        = 0;
    frames      = 0;
    err_idx     = 0;
    cyc         = 0;
    test_no     = 0;
    n_tests     = 0;
    n_checks    = 0;
    n_errors    = 0;
    cycle_limit = 0;
    void'($urandom(32'h901e_ad17));
    for (int i = 0; i < 3 * MAX_TESTS; i++) test_mem[i] = 16'hffff;
    $readmemh("dv/lane_tests.dat", test_mem);
    while (n_tests < MAX_TESTS && test_mem[3 * n_tests] != 16'hffff) begin
      cycle_limit += int'(test_mem[3 * n_tests + 1]) * FRAME_LEN + 200;
      n_tests++;
    end
    if (n_tests == 0) begin
      $display("Error: no tests were read from dv/lane_tests.dat");
      n_errors++;
    end

    for (test_no = 0; test_no < n_tests; test_no++) begin
      skew    = int'(test_mem[3 * test_no]);
      frames  = int'(test_mem[3 * test_no + 1]);
      err_idx = int'(test_mem[3 * test_no + 2]);
      idle    = (test_no == 0) ? 0 : int'($urandom % 8);
      repeat (HOLD_CYCLES + idle) step_cycle();
      compare_value("o_aligned", 32'(aligned), 32'd0);
      compare_value("o_locked", 32'(locked), 32'd0);
      compare_value("o_frame_ok", 32'(frame_ok), 32'd0);
      compare_value("o_frame_cnt", 32'(frame_cnt), 32'd0);
      compare_value("o_err_cnt", 32'(err_cnt), 32'd0);

      // a skewed lane needs one more word to finish the last frame
      exp_frames = frames - ((skew != 0) ? 1 : 0) - ((err_idx != 0) ? 1 : 0);
      // last word, extra skew word, two aligner stages, then the checker
      exp_first  = ((err_idx != 0) ? FRAME_LEN : 0) + FRAME_LEN - 1
                   + ((skew != 0) ? 1 : 0) + 3;

      cyc         = 0;
      pulses      = 0;
      first_pulse = 0;
      tx_rstn     = 1'b1;
      // ends as an unskewed lane counts its last frame
      run_len     = frames * FRAME_LEN + 2;
      while (cyc < run_len) begin
        step_cycle();
        compare_value("o_txd", txd, exp_tx_word(cyc % FRAME_LEN));
        compare_value("o_txk", 32'(txk), 32'(exp_tx_flags(cyc % FRAME_LEN)));
        if (frame_ok) begin
          pulses++;
          if (first_pulse == 0) first_pulse = cyc;
        end
        compare_value("o_locked", 32'(locked),
                      (exp_frames > 0 && cyc >= exp_first) ? 32'd1 : 32'd0);
        if (cyc == FRAME_LEN) compare_value("o_aligned", 32'(aligned), 32'd1);
        if (err_idx == 0) compare_value("o_err_cnt", 32'(err_cnt), 32'd0);
      end

      compare_value("o_frame_cnt", 32'(frame_cnt), 32'(exp_frames));
      compare_value("o_frame_ok pulses", 32'(pulses), 32'(exp_frames));
      if (exp_frames > 0) compare_value("o_frame_ok first cycle", 32'(first_pulse),
                                        32'(exp_first));
      if (err_idx != 0) compare_value("o_err_cnt", 32'(err_cnt), 32'd1);
      compare_value("o_aligned", 32'(aligned), 32'd1);
      tx_rstn = 1'b0;
    end

    $display("Tests run: %0d, checks: %0d, errors: %0d", n_tests, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* dv/lane_tests.dat */
// columns: skew frames err_idx, all hex, one test per line
// err_idx is the count word of the first frame with bit 0 flipped, 0 for none
0 3 0
1 3 0
2 3 0
3 3 0
0 4 5
1 4 1
2 4 0c
3 4 18
2 5 0
1 2 0
0 2 0c
3 6 0

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
  --top-module lane_test_tb -f src.f -o lane_test_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "verilator build failed, see build.log"
  exit 1
fi

./obj_dir/lane_test_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
  echo "simulation exited with an error, see sim.log"
  exit 1
fi

if grep -q "Simulation finished: PASS" sim.log; then
  echo "result: pass"
  exit 0
fi
echo "result: fail, see sim.log"
exit 1

/* src.f */
design/lane_test_pkg.sv
design/lane_stream_if.sv
design/tx_pattern_gen.sv
design/word_aligner.sv
design/pattern_checker.sv
design/lane_test_top.sv
dv/lane_test_props.sv
dv/lane_test_tb.sv
